//--- list.f
+incdir+tb
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/rv_full_decode.sv
verilog/rv_comp_decode.sv
verilog/decode_stage.sv
verilog/decode_top.sv
tb/decode_top_assert.sv
tb/tb_decode_top.sv

//--- Bender.yml
package:
  name: rv_decode_stage

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/decode_pkg.sv
  - verilog/rv_full_decode.sv
  - verilog/rv_comp_decode.sv
  - verilog/decode_stage.sv
  - verilog/decode_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/decode_top_assert.sv
      - tb/tb_decode_top.sv

//--- tb/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected bundle for a full 32-bit slot word
function automatic bundle_t expect_full(input logic [31:0] w);
    bundle_t    b;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       is_imm;
    logic       is_reg;
    logic       is_w;
    logic       ok;
    b = '0;
    ok = 1'b0;
    f7 = w[31:25];
    f3 = w[14:12];
    is_imm = (w[6:2] == OPC_OP_IMM) || (w[6:2] == OPC_OP_IMM_32);
    is_reg = (w[6:2] == OPC_OP) || (w[6:2] == OPC_OP_32);
    is_w = (w[6:2] == OPC_OP_IMM_32) || (w[6:2] == OPC_OP_32);
    b.rd = w[11:7];
    b.rs1 = w[19:15];
    b.rs2 = w[24:20];
    if ((w[6:2] == OPC_LUI) || (w[6:2] == OPC_AUIPC)) begin
        ok = 1'b1;
        b.imm = {w[31:12], 12'h000};
    end else if (is_imm || is_reg) begin
        if (is_imm) begin
            b.imm = {{20{w[31]}}, w[31:20]};
        end
        case (f3)
            F3_ADD: begin
                ok = is_imm || (f7 == 7'h00) || (f7 == 7'h20);
                b.xarith.sub = is_reg && (f7 == 7'h20);
                b.xarith.word = is_w;
            end
            F3_SLL, F3_SR: begin
                // 64-bit immediate shifts own bit 25 as shamt[5]
                if (is_imm && !is_w) begin
                    ok = (f7[6:1] == 6'h00) || ((f3 == F3_SR) && (f7[6:1] == 6'h10));
                end else begin
                    ok = (f7 == 7'h00) || ((f3 == F3_SR) && (f7 == 7'h20));
                end
                b.pipe = PIPE_XLOGIC;
                b.xlogic.opsel = XLOGIC_OP_SHF;
                b.xlogic.word = is_w;
                b.xlogic.right = f3 == F3_SR;
                b.xlogic.arith = (f3 == F3_SR) && w[30];
            end
            F3_SLT, F3_SLTU: begin
                ok = !is_w && (is_imm || (f7 == 7'h00));
                b.xarith.opsel = XARITH_OP_SLT;
                b.xarith.unsgn = f3 == F3_SLTU;
            end
            default: begin
                ok = !is_w && (is_imm || (f7 == 7'h00));
                b.pipe = PIPE_XLOGIC;
                b.xlogic.opsel = (f3 == F3_XOR) ? XLOGIC_OP_XOR :
                                 (f3 == F3_OR) ? XLOGIC_OP_OR : XLOGIC_OP_AND;
            end
        endcase
    end
    if (w[1:0] != 2'b11) begin
        ok = 1'b0;
    end
    b.legal = ok;
    return ok ? b : '0;
endfunction

// expected bundle for a 16-bit compressed half
function automatic bundle_t expect_comp(input logic [15:0] h);
    bundle_t     b;
    reg_addr_t   rd;
    reg_addr_t   rs2;
    reg_addr_t   rdp;
    reg_addr_t   rs2p;
    logic [31:0] simm;
    logic [31:0] uimm;
    logic        ok;
    b = '0;
    ok = 1'b0;
    rd = h[11:7];
    rs2 = h[6:2];
    rdp = {2'b01, h[9:7]};
    rs2p = {2'b01, h[4:2]};
    simm = {{26{h[12]}}, h[12], h[6:2]};
    uimm = {26'd0, h[12], h[6:2]};
    case ({h[15:13], h[1:0]})
        // c.addi
        5'b000_01: begin
            ok = 1'b1;
            b.rd = rd;
            b.rs1 = rd;
            b.imm = simm;
        end
        // c.li
        5'b010_01: begin
            ok = rd != 5'd0;
            b.rd = rd;
            b.imm = simm;
        end
        5'b100_01: begin
            b.rd = rdp;
            b.rs1 = rdp;
            b.pipe = PIPE_XLOGIC;
            if (h[11] == 1'b0) begin
                ok = 1'b1;
                b.imm = uimm;
                b.xlogic.opsel = XLOGIC_OP_SHF;
                b.xlogic.right = 1'b1;
                b.xlogic.arith = h[10];
            end else if (h[10] == 1'b0) begin
                ok = 1'b1;
                b.imm = simm;
                b.xlogic.opsel = XLOGIC_OP_AND;
            end else begin
                ok = !h[12];
                b.rs2 = rs2p;
                case (h[6:5])
                    2'b00: begin
                        b.pipe = PIPE_XARITH;
                        b.xarith.sub = 1'b1;
                    end
                    2'b01: b.xlogic.opsel = XLOGIC_OP_XOR;
                    2'b10: b.xlogic.opsel = XLOGIC_OP_OR;
                    default: b.xlogic.opsel = XLOGIC_OP_AND;
                endcase
            end
        end
        // c.slli
        5'b000_10: begin
            ok = rd != 5'd0;
            b.rd = rd;
            b.rs1 = rd;
            b.imm = uimm;
            b.pipe = PIPE_XLOGIC;
            b.xlogic.opsel = XLOGIC_OP_SHF;
        end
        // c.mv or c.add
        5'b100_10: begin
            ok = (rd != 5'd0) && (rs2 != 5'd0);
            b.rd = rd;
            b.rs1 = h[12] ? rd : 5'd0;
            b.rs2 = rs2;
        end
        default: begin
            ok = 1'b0;
        end
    endcase
    b.legal = ok;
    return ok ? b : '0;
endfunction

`endif

//--- tb/tb_decode_top.sv
`timescale 1ns/100ps

module tb_decode_top;
    import rv_isa_pkg::*;
    import decode_pkg::*;

    localparam int P_SLOTS    = 2;
    localparam int CNT_W      = count_w(P_SLOTS);
    localparam int N_ITEMS    = 400;
    localparam int MAX_CYCLES = 4 * N_ITEMS + 100;

    `include "decode_model.svh"

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic [INST_W-1:0]     i_inst [P_SLOTS];
    logic [P_SLOTS-1:0]    i_compressed;
    logic [CNT_W-1:0]      i_count;
    logic                  i_input_valid;
    logic                  i_output_ready;
    logic                  o_input_ready;
    logic                  o_output_valid;
    bundle_t               o_bundle [P_SLOTS];
    logic [CNT_W-1:0]      o_count;

    bundle_t [P_SLOTS-1:0] exp_q [$];
    logic [CNT_W-1:0]      exp_count_q [$];
    bundle_t [P_SLOTS-1:0] head_bundle = '0;
    logic [CNT_W-1:0]      head_count = '0;
    logic                  head_valid = 1'b0;
    int unsigned           sent = 0;
    int unsigned           received = 0;
    int unsigned           cycles = 0;

    always #20 i_clk = !i_clk;

    decode_top #(
        .P_SLOTS (P_SLOTS)
    ) uut (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_inst         (i_inst),
        .i_compressed   (i_compressed),
        .i_count        (i_count),
        .i_input_valid  (i_input_valid),
        .i_output_ready (i_output_ready),
        .o_input_ready  (o_input_ready),
        .o_output_valid (o_output_valid),
        .o_bundle       (o_bundle),
        .o_count        (o_count)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    // mostly supported classes and some random opcodes
    function automatic logic [31:0] random_full();
        logic [31:0] w;
        w = $urandom();
        w[1:0] = 2'b11;
        case ($urandom_range(7))
            0: w[6:2] = OPC_OP_IMM;
            1: w[6:2] = OPC_OP_IMM_32;
            2: w[6:2] = OPC_OP;
            3: w[6:2] = OPC_OP_32;
            4: w[6:2] = OPC_LUI;
            5: w[6:2] = OPC_AUIPC;
            default: w[1:0] = 2'($urandom());
        endcase
        case ($urandom_range(4))
            0: w[31:25] = 7'h00;
            1: w[31:25] = 7'h20;
            2: w[31:25] = 7'h01;
            3: w[31:25] = 7'h21;
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic [15:0] random_comp();
        logic [15:0] h;
        h = $urandom();
        case ($urandom_range(5))
            0: {h[15:13], h[1:0]} = 5'b000_01;
            1: {h[15:13], h[1:0]} = 5'b010_01;
            2: {h[15:13], h[1:0]} = 5'b100_01;
            3: {h[15:13], h[1:0]} = 5'b000_10;
            4: {h[15:13], h[1:0]} = 5'b100_10;
            default: ;
        endcase
        // reach the x0 legality rules
        if ($urandom_range(5) == 0) begin
            h[11:7] = 5'd0;
        end
        if ($urandom_range(5) == 0) begin
            h[6:2] = 5'd0;
        end
        return h;
    endfunction

    task automatic load_slots();
        logic [P_SLOTS-1:0] comp;
        comp = P_SLOTS'($urandom());
        for (int s = 0; s < P_SLOTS; s++) begin
            i_inst[s] <= comp[s] ? {16'($urandom()), random_comp()} : random_full();
        end
        i_compressed <= comp;
        i_count <= CNT_W'($urandom_range(P_SLOTS - 1));
    endtask

    // head is the oldest accepted item
    always @(posedge i_clk) begin : scoreboard
        bundle_t [P_SLOTS-1:0] item;
        if (i_rst_n) begin
            if (o_output_valid && i_output_ready && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(exp_count_q.pop_front());
                received++;
            end
            if (i_input_valid && o_input_ready) begin
                for (int s = 0; s < P_SLOTS; s++) begin
                    item[s] = i_compressed[s] ? expect_comp(i_inst[s][15:0])
                                              : expect_full(i_inst[s]);
                end
                exp_q.push_back(item);
                exp_count_q.push_back(i_count);
            end
            head_valid = exp_q.size() > 0;
            if (head_valid) begin
                head_bundle = exp_q[0];
                head_count = exp_count_q[0];
            end
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n) o_output_valid |-> head_valid)
    else abort_run("output valid with no accepted item outstanding");

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_output_valid && i_output_ready |-> o_count == head_count)
    else abort_run($sformatf("Mismatch o_count: got %h expected %h",
                             $sampled(o_count), $sampled(head_count)));

    for (genvar s = 0; s < P_SLOTS; s++) begin : g_slot_check
        assert property (@(posedge i_clk) disable iff (!i_rst_n)
            o_output_valid && i_output_ready |-> o_bundle[s] == head_bundle[s])
        else abort_run($sformatf("Mismatch o_bundle[%0d]: got %h expected %h", s,
                                 $sampled(o_bundle[s]), $sampled(head_bundle[s])));
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end else if (uut.u_assert.fail_count != 0) begin
            abort_run("a handshake or reset assertion on decode_top failed");
        end
    end

    initial begin
        void'($urandom(32'h29d8e829));
        i_rst_n <= 1'b0;
        i_compressed <= '0;
        i_count <= '0;
        i_input_valid <= 1'b0;
        i_output_ready <= 1'b0;
        for (int s = 0; s < P_SLOTS; s++) begin
            i_inst[s] <= '0;
        end
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;

        while (sent < N_ITEMS) begin
            @(posedge i_clk);
            if (i_input_valid && o_input_ready) begin
                sent++;
            end
            // new item only once the current one is gone
            if (!i_input_valid || o_input_ready) begin
                if (sent < N_ITEMS) begin
                    load_slots();
                    i_input_valid <= ($urandom_range(3) != 0);
                end else begin
                    i_input_valid <= 1'b0;
                end
            end
            i_output_ready <= ($urandom_range(3) != 0);
        end

        while (received < N_ITEMS) begin
            @(posedge i_clk);
            i_output_ready <= ($urandom_range(1) != 0);
        end
        @(posedge i_clk);

        if (uut.u_assert.fail_count != 0) begin
            abort_run("a handshake or reset assertion on decode_top failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- tb/decode_top_assert.sv
`timescale 1ns/100ps

module decode_top_assert #(
    parameter int P_SLOTS = 2
) (
    input logic                                    i_clk,
    input logic                                    i_rst_n,
    input logic                                    i_output_ready,
    input logic                                    i_input_ready,
    input logic                                    i_output_valid,
    input decode_pkg::bundle_t                     i_bundle [P_SLOTS],
    input logic [decode_pkg::count_w(P_SLOTS)-1:0] i_count
);
    import decode_pkg::*;

    logic [P_SLOTS*$bits(bundle_t)-1:0] bundle_flat;
    int unsigned                        fail_count = 0;

    always_comb begin
        for (int s = 0; s < P_SLOTS; s++) begin
            bundle_flat[s*$bits(bundle_t) +: $bits(bundle_t)] = i_bundle[s];
        end
    end

    // held in reset
    assert property (@(posedge i_clk)
        !i_rst_n |-> !i_output_valid && i_input_ready && i_count == '0 && bundle_flat == '0)
    else begin
        fail_count++;
        $error("outputs are not in their reset state while reset is applied");
    end

    assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_output_valid && i_input_ready)
    else begin
        fail_count++;
        $error("stage is not empty and ready right after reset");
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_output_valid || i_output_ready |-> i_input_ready)
    else begin
        fail_count++;
        $error("input not ready although the output register is free or draining");
    end

    // one item in flight while stalled
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_output_valid && !i_output_ready |-> !i_input_ready)
    else begin
        fail_count++;
        $error("input ready while the output is stalled");
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_output_valid && !i_output_ready
        |=> i_output_valid && $stable(i_count) && $stable(bundle_flat))
    else begin
        fail_count++;
        $error("stalled output changed before it was taken");
    end

endmodule

bind decode_top decode_top_assert #(
    .P_SLOTS (P_SLOTS)
) u_assert (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_output_ready (i_output_ready),
    .i_input_ready  (o_input_ready),
    .i_output_valid (o_output_valid),
    .i_bundle       (o_bundle),
    .i_count        (o_count)
);

//--- verilog/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_top #(
    parameter int P_SLOTS = 2
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic [decode_pkg::INST_W-1:0]          i_inst [P_SLOTS],
    input  logic [P_SLOTS-1:0]                     i_compressed,
    input  logic [decode_pkg::count_w(P_SLOTS)-1:0] i_count,
    input  logic                                   i_input_valid,
    input  logic                                   i_output_ready,
    output logic                                   o_input_ready,
    output logic                                   o_output_valid,
    output decode_pkg::bundle_t                    o_bundle [P_SLOTS],
    output logic [decode_pkg::count_w(P_SLOTS)-1:0] o_count
);
    import decode_pkg::*;

    bundle_t full_bundle [P_SLOTS];
    bundle_t comp_bundle [P_SLOTS];

    // both decoders see every slot, the stage picks
    generate
        for (genvar s = 0; s < P_SLOTS; s++) begin : g_slot
            rv_full_decode u_full (
                .i_inst   (i_inst[s]),
                .o_bundle (full_bundle[s])
            );

            rv_comp_decode u_comp (
                .i_inst   (i_inst[s][CINST_W-1:0]),
                .o_bundle (comp_bundle[s])
            );
        end
    endgenerate

    decode_stage #(
        .P_SLOTS (P_SLOTS)
    ) u_stage (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .o_input_ready  (o_input_ready),
        .i_full         (full_bundle),
        .i_comp         (comp_bundle),
        .i_compressed   (i_compressed),
        .i_count        (i_count),
        .i_output_ready (i_output_ready),
        .o_output_valid (o_output_valid),
        .o_bundle       (o_bundle),
        .o_count        (o_count)
    );

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
    parameter int P_SLOTS = 2
) (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_input_valid,
    output logic                                   o_input_ready,
    input  decode_pkg::bundle_t                    i_full [P_SLOTS],
    input  decode_pkg::bundle_t                    i_comp [P_SLOTS],
    input  logic [P_SLOTS-1:0]                     i_compressed,
    input  logic [decode_pkg::count_w(P_SLOTS)-1:0] i_count,
    input  logic                                   i_output_ready,
    output logic                                   o_output_valid,
    output decode_pkg::bundle_t                    o_bundle [P_SLOTS],
    output logic [decode_pkg::count_w(P_SLOTS)-1:0] o_count
);
    import decode_pkg::*;

    bundle_t                      picked [P_SLOTS];
    bundle_t                      bundle_q [P_SLOTS];
    logic [count_w(P_SLOTS)-1:0]  count_q;
    logic                         valid_q;
    logic                         take_in;

    always_comb begin
        for (int s = 0; s < P_SLOTS; s++) begin
            picked[s] = i_compressed[s] ? i_comp[s] : i_full[s];
        end
    end

    // register free, or drained this cycle
    assign o_input_ready = !valid_q || i_output_ready;
    assign take_in = i_input_valid && o_input_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (o_input_ready) begin
            valid_q <= i_input_valid;
        end
    end

    // holds while stalled
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < P_SLOTS; s++) begin
                bundle_q[s] <= '0;
            end
            count_q <= '0;
        end else if (take_in) begin
            for (int s = 0; s < P_SLOTS; s++) begin
                bundle_q[s] <= picked[s];
            end
            count_q <= i_count;
        end
    end

    assign o_output_valid = valid_q;
    assign o_bundle = bundle_q;
    assign o_count = count_q;

endmodule

`default_nettype wire

//--- verilog/rv_comp_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_comp_decode (
    input  logic [decode_pkg::CINST_W-1:0] i_inst,
    output decode_pkg::bundle_t            o_bundle
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    cq_e               quadrant;
    logic [2:0]        funct3;
    reg_addr_t         rd_full;
    reg_addr_t         rs2_full;
    reg_addr_t         rd_prime;
    reg_addr_t         rs2_prime;
    logic [5:0]        imm6;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_zext;
    bundle_t           dec;

    assign quadrant = cq_e'(i_inst[1:0]);
    assign funct3   = i_inst[15:13];
    assign rd_full  = i_inst[11:7];
    assign rs2_full = i_inst[6:2];

    // x8..x15
    assign rd_prime  = CREG_BASE + reg_addr_t'(i_inst[9:7]);
    assign rs2_prime = CREG_BASE + reg_addr_t'(i_inst[4:2]);

    assign imm6     = {i_inst[12], i_inst[6:2]};
    assign imm_sext = {{(DATA_W-6){imm6[5]}}, imm6};
    assign imm_zext = {{(DATA_W-6){1'b0}}, imm6};

    always_comb begin
        dec = '0;
        case (quadrant)
            CQ1: begin
                case (funct3)
                    CF3_ADDI: begin
                        dec.legal = 1'b1;
                        dec.rd = rd_full;
                        dec.rs1 = rd_full;
                        dec.imm = imm_sext;
                    end
                    // rs1 stays x0
                    CF3_LI: begin
                        dec.legal = rd_full != '0;
                        dec.rd = rd_full;
                        dec.imm = imm_sext;
                    end
                    CF3_MISC_ALU: begin
                        dec.rd = rd_prime;
                        dec.rs1 = rd_prime;
                        case (i_inst[11:10])
                            // srli, srai
                            2'b00, 2'b01: begin
                                dec.legal = 1'b1;
                                dec.imm = imm_zext;
                                dec.pipe = PIPE_XLOGIC;
                                dec.xlogic.opsel = XLOGIC_OP_SHF;
                                dec.xlogic.right = 1'b1;
                                dec.xlogic.arith = i_inst[10];
                            end
                            2'b10: begin
                                dec.legal = 1'b1;
                                dec.imm = imm_sext;
                                dec.pipe = PIPE_XLOGIC;
                                dec.xlogic.opsel = XLOGIC_OP_AND;
                            end
                            // bit 12 set is subw/addw, not handled here
                            2'b11: begin
                                dec.legal = !i_inst[12];
                                dec.rs2 = rs2_prime;
                                dec.pipe = (i_inst[6:5] == 2'b00) ? PIPE_XARITH : PIPE_XLOGIC;
                                case (i_inst[6:5])
                                    2'b00: dec.xarith.sub = 1'b1;
                                    2'b01: dec.xlogic.opsel = XLOGIC_OP_XOR;
                                    2'b10: dec.xlogic.opsel = XLOGIC_OP_OR;
                                    2'b11: dec.xlogic.opsel = XLOGIC_OP_AND;
                                endcase
                            end
                        endcase
                    end
                    default: begin
                        dec.legal = 1'b0;
                    end
                endcase
            end
            CQ2: begin
                case (funct3)
                    CF3_SLLI: begin
                        dec.legal = rd_full != '0;
                        dec.rd = rd_full;
                        dec.rs1 = rd_full;
                        dec.imm = imm_zext;
                        dec.pipe = PIPE_XLOGIC;
                        dec.xlogic.opsel = XLOGIC_OP_SHF;
                    end
                    // mv reads x0 as rs1, add reads rd
                    CF3_MV_ADD: begin
                        dec.legal = (rd_full != '0) && (rs2_full != '0);
                        dec.rd = rd_full;
                        dec.rs1 = i_inst[12] ? rd_full : '0;
                        dec.rs2 = rs2_full;
                    end
                    default: begin
                        dec.legal = 1'b0;
                    end
                endcase
            end
            default: begin
                dec.legal = 1'b0;
            end
        endcase
    end

    assign o_bundle = dec.legal ? dec : '0;

endmodule

`default_nettype wire

//--- verilog/rv_full_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_full_decode (
    input  logic [decode_pkg::INST_W-1:0] i_inst,
    output decode_pkg::bundle_t           o_bundle
);
    import rv_isa_pkg::*;
    import decode_pkg::*;

    opc_e              opcode;
    cq_e               quadrant;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic              reg_op;
    logic              word;
    logic              f7_base;
    logic              f7_alt;
    logic              imm_base;
    logic              imm_alt;
    logic [DATA_W-1:0] imm_i;
    logic [DATA_W-1:0] imm_u;
    bundle_t           dec;

    assign opcode   = opc_e'(i_inst[6:2]);
    assign quadrant = cq_e'(i_inst[1:0]);
    assign funct3   = i_inst[14:12];
    assign funct7   = i_inst[31:25];

    assign reg_op = (opcode == OPC_OP) || (opcode == OPC_OP_32);
    assign word   = (opcode == OPC_OP_IMM_32) || (opcode == OPC_OP_32);

    assign f7_base = funct7 == F7_BASE;
    assign f7_alt  = funct7 == F7_ALT;

    // shamt is 6 bits wide for rv64, 5 bits for the word forms
    assign imm_base = word ? f7_base : (funct7[6:1] == F6_BASE);
    assign imm_alt  = word ? f7_alt : (funct7[6:1] == F6_ALT);

    assign imm_i = {{(DATA_W-12){i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'h000};

    always_comb begin
        dec = '0;
        dec.rd  = i_inst[11:7];
        dec.rs1 = i_inst[19:15];
        dec.rs2 = i_inst[24:20];

        case (opcode)
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: begin
                dec.imm = reg_op ? '0 : imm_i;
                case (funct3)
                    // add, sub and their word forms
                    F3_ADD: begin
                        dec.legal = !reg_op || f7_base || f7_alt;
                        dec.pipe = PIPE_XARITH;
                        dec.xarith.opsel = XARITH_OP_ADD;
                        dec.xarith.sub = reg_op && funct7[5];
                        dec.xarith.word = word;
                    end
                    F3_SLL: begin
                        dec.legal = reg_op ? f7_base : imm_base;
                        dec.pipe = PIPE_XLOGIC;
                        dec.xlogic.opsel = XLOGIC_OP_SHF;
                        dec.xlogic.word = word;
                    end
                    // logical or arithmetic by bit 30
                    F3_SR: begin
                        dec.legal = reg_op ? (f7_base || f7_alt) : (imm_base || imm_alt);
                        dec.pipe = PIPE_XLOGIC;
                        dec.xlogic.opsel = XLOGIC_OP_SHF;
                        dec.xlogic.word = word;
                        dec.xlogic.right = 1'b1;
                        dec.xlogic.arith = i_inst[30];
                    end
                    // no word forms
                    F3_SLT, F3_SLTU: begin
                        dec.legal = !word && (!reg_op || f7_base);
                        dec.pipe = PIPE_XARITH;
                        dec.xarith.opsel = XARITH_OP_SLT;
                        dec.xarith.unsgn = funct3 == F3_SLTU;
                    end
                    F3_XOR, F3_OR, F3_AND: begin
                        dec.legal = !word && (!reg_op || f7_base);
                        dec.pipe = PIPE_XLOGIC;
                        dec.xlogic.opsel = (funct3 == F3_XOR) ? XLOGIC_OP_XOR :
                                           (funct3 == F3_OR)  ? XLOGIC_OP_OR  : XLOGIC_OP_AND;
                    end
                endcase
            end
            // auipc adds the pc in the unit
            OPC_LUI, OPC_AUIPC: begin
                dec.legal = 1'b1;
                dec.imm = imm_u;
                dec.pipe = PIPE_XARITH;
                dec.xarith.opsel = XARITH_OP_ADD;
            end
            default: begin
                dec.legal = 1'b0;
            end
        endcase

        // a compressed encoding is never a 32-bit instruction
        if (quadrant != CQ_NONE) begin
            dec.legal = 1'b0;
        end
    end

    assign o_bundle = dec.legal ? dec : '0;

endmodule

`default_nettype wire

//--- verilog/decode_pkg.sv
package decode_pkg;

    localparam int DATA_W  = 32;
    localparam int INST_W  = 32;
    localparam int CINST_W = 16;

    typedef enum logic {
        PIPE_XARITH = 1'b0,
        PIPE_XLOGIC = 1'b1
    } pipe_e;

    typedef enum logic {
        XARITH_OP_ADD = 1'b0,
        XARITH_OP_SLT = 1'b1
    } xarith_op_e;

    typedef enum logic [1:0] {
        XLOGIC_OP_AND = 2'b00,
        XLOGIC_OP_OR  = 2'b01,
        XLOGIC_OP_XOR = 2'b10,
        XLOGIC_OP_SHF = 2'b11
    } xlogic_op_e;

    typedef struct packed {
        xarith_op_e opsel;
        logic       sub;
        logic       unsgn;
        logic       word;
    } xarith_ctl_t;

    typedef struct packed {
        xlogic_op_e opsel;
        logic       invert;
        logic       word;
        logic       right;
        logic       arith;
    } xlogic_ctl_t;

    typedef struct packed {
        logic                  legal;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::reg_addr_t rs2;
        rv_isa_pkg::reg_addr_t rs1;
        logic [DATA_W-1:0]     imm;
        pipe_e                 pipe;
        xarith_ctl_t           xarith;
        xlogic_ctl_t           xlogic;
    } bundle_t;

    // width of a slot count held as count minus one
    function automatic int count_w(input int slots);
        return (slots > 1) ? $clog2(slots) : 1;
    endfunction

endpackage

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // x8, first register a 3-bit compressed field can name
    localparam reg_addr_t CREG_BASE = 5'd8;

    // major opcode, inst[6:2]
    typedef enum logic [4:0] {
        OPC_OP_IMM    = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_OP_IMM_32 = 5'b00110,
        OPC_OP        = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_OP_32     = 5'b01110
    } opc_e;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // rv64 immediate shifts, shamt[5] sits in bit 25
    localparam logic [5:0] F6_BASE = 6'b000000;
    localparam logic [5:0] F6_ALT  = 6'b010000;

    // inst[1:0], 2'b11 marks a full 32-bit word
    typedef enum logic [1:0] {
        CQ0     = 2'b00,
        CQ1     = 2'b01,
        CQ2     = 2'b10,
        CQ_NONE = 2'b11
    } cq_e;

    localparam logic [2:0] CF3_ADDI     = 3'b000;
    localparam logic [2:0] CF3_LI       = 3'b010;
    localparam logic [2:0] CF3_MISC_ALU = 3'b100;
    localparam logic [2:0] CF3_SLLI     = 3'b000;
    localparam logic [2:0] CF3_MV_ADD   = 3'b100;

endpackage
